// ==== build.f ====
+incdir+source
source/ctr_pkg.sv
source/ctr_cmd_if.sv
source/axil_cmd_slave.sv
source/counter_decr.sv
source/axil_status_reader.sv
source/ctr_axil_top.sv
tests/ctr_axil_tb.sv

// ==== source/axil_cmd_slave.sv ====
// --------------------------------------------------------------------------
// Counter command slave
// AXI4-Lite write channel of the counter block. Holds the initial-value
// register and turns CMD writes into one-cycle decrement and reinit pulses
// --------------------------------------------------------------------------

`include "ctr_defs.svh"

module axil_cmd_slave (
  input  logic           clk,
  input  logic           reset,
  // Write address channel
  input  ctr_pkg::addr_t awaddr,
  input  logic           awvalid,
  output logic           awready,
  // Write data channel
  input  ctr_pkg::data_t wdata,
  input  logic [3:0]     wstrb,
  input  logic           wvalid,
  output logic           wready,
  // Write response channel
  output ctr_pkg::resp_t bresp,
  output logic           bvalid,
  input  logic           bready,
  // Commands towards the counter
  ctr_cmd_if.cmd         cmd
);

  ctr_pkg::wr_state_e wr_state;
  logic               wr_accept;
  logic               is_init;
  logic               is_cmd;
  ctr_pkg::value_t    init_clip;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Address and data are only taken together, and only while idle
  assign awready   = (wr_state == ctr_pkg::WR_IDLE);
  assign wready    = (wr_state == ctr_pkg::WR_IDLE);
  assign bvalid    = (wr_state == ctr_pkg::WR_RESP);
  assign wr_accept = awready && awvalid && wvalid;

  // Byte strobes in wstrb are not looked at, every write is a full word

  // Offset decode
  assign is_init = (awaddr == `CTR_REG_INIT);
  assign is_cmd  = (awaddr == `CTR_REG_CMD);

  // Initial values above the range are clipped to the top of the range
  assign init_clip = (wdata[`CTR_VALUE_W-1:0] > `CTR_MAX_VALUE) ?
                     ctr_pkg::value_t'(`CTR_MAX_VALUE) : wdata[`CTR_VALUE_W-1:0];

  // One transaction at a time; the response holds until the master takes it
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state <= ctr_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        ctr_pkg::WR_IDLE: if (wr_accept) wr_state <= ctr_pkg::WR_RESP;
        ctr_pkg::WR_RESP: if (bready) wr_state <= ctr_pkg::WR_IDLE;
        default:          wr_state <= ctr_pkg::WR_IDLE;
      endcase
    end
  end

  // Response code is captured with the write
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp <= (is_init || is_cmd) ? ctr_pkg::RESP_OKAY : ctr_pkg::RESP_SLVERR;
    end
  end

  // --------------------------------------------------------------------------
  // Registers and command pulses
  // --------------------------------------------------------------------------

  // The counter also reloads from this register out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.initial_value <= ctr_pkg::value_t'(`CTR_MAX_VALUE);
    end else if (wr_accept && is_init) begin
      cmd.initial_value <= init_clip;
    end
  end

  // Pulses line up with the rise of bvalid
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.decr_valid <= 1'b0;
      cmd.reinit     <= 1'b0;
    end else begin
      cmd.decr_valid <= wr_accept && is_cmd;
      cmd.reinit     <= wr_accept && is_cmd && wdata[`CTR_CMD_REINIT_BIT];
    end
  end

  // Decrement amount is only looked at while decr_valid is high
  always_ff @(posedge clk) begin
    if (wr_accept && is_cmd) begin
      cmd.decr <= wdata[`CTR_DECR_W-1:0];
    end
  end

  // Each CMD write gives exactly one decrement
  decr_single_cycle_a : assert property (@(posedge clk) disable iff (reset)
    cmd.decr_valid |=> !cmd.decr_valid);

  // Response stays offered until the master accepts it
  bvalid_hold_a : assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid);

endmodule

// ==== source/axil_status_reader.sv ====
// --------------------------------------------------------------------------
// Counter status reader
// Counts wrap events of the counter and serves the AXI4-Lite read channel
// for the initial value, the current value and the wrap count
// --------------------------------------------------------------------------

`include "ctr_defs.svh"

module axil_status_reader (
  input  logic           clk,
  input  logic           reset,
  // Read address channel
  input  ctr_pkg::addr_t araddr,
  input  logic           arvalid,
  output logic           arready,
  // Read data channel
  output ctr_pkg::data_t rdata,
  output ctr_pkg::resp_t rresp,
  output logic           rvalid,
  input  logic           rready,
  // Counter commands and state
  ctr_cmd_if.mon         mon
);

  ctr_pkg::rd_state_e rd_state;
  logic               rd_accept;
  ctr_pkg::value_t    base_value;
  logic               wrap_event;
  ctr_pkg::wrap_t     wrap_count;
  ctr_pkg::data_t     rd_data_mux;
  ctr_pkg::resp_t     rd_resp_mux;

  // --------------------------------------------------------------------------
  // Wrap counter
  // --------------------------------------------------------------------------

  // Same base the counter uses for this command
  assign base_value = mon.reinit ? mon.initial_value : mon.value;

  // A decrement past the base takes the counter below zero
  assign wrap_event = mon.decr_valid && (mon.decr > base_value);

  // Rolls over at its own width
  always_ff @(posedge clk) begin
    if (reset) begin
      wrap_count <= '0;
    end else if (wrap_event) begin
      wrap_count <= wrap_count + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Read channel
  // --------------------------------------------------------------------------

  assign arready   = (rd_state == ctr_pkg::RD_IDLE);
  assign rvalid    = (rd_state == ctr_pkg::RD_DATA);
  assign rd_accept = arready && arvalid;

  // Register map, unmapped offsets read as zero with an error
  always_comb begin
    rd_data_mux = '0;
    rd_resp_mux = ctr_pkg::RESP_OKAY;
    case (araddr)
      `CTR_REG_INIT:  rd_data_mux = ctr_pkg::data_t'(mon.initial_value);
      `CTR_REG_VALUE: rd_data_mux = ctr_pkg::data_t'(mon.value);
      `CTR_REG_WRAPS: rd_data_mux = ctr_pkg::data_t'(wrap_count);
      default:        rd_resp_mux = ctr_pkg::RESP_SLVERR;
    endcase
  end

  // One read in flight; data waits for rready
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state <= ctr_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        ctr_pkg::RD_IDLE: if (rd_accept) rd_state <= ctr_pkg::RD_DATA;
        ctr_pkg::RD_DATA: if (rready) rd_state <= ctr_pkg::RD_IDLE;
        default:          rd_state <= ctr_pkg::RD_IDLE;
      endcase
    end
  end

  // Data is sampled at acceptance, later counter changes do not leak in
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata <= rd_data_mux;
      rresp <= rd_resp_mux;
    end
  end

  // Offered data must not move before the master takes it
  rdata_stable_a : assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== source/counter_decr.sv ====
// --------------------------------------------------------------------------
// Wrapping down-counter
// Subtracts a bounded decrement from the current or the initial value and
// wraps below zero back into the range 0 to the maximum value
// --------------------------------------------------------------------------

`include "ctr_defs.svh"

module counter_decr (
  input  logic   clk,
  input  logic   reset,
  ctr_cmd_if.ctr ctr
);

  // Codes between the top of the range and the top of the vector
  localparam int MARGIN = (2 ** `CTR_VALUE_W) - 1 - `CTR_MAX_VALUE;

  ctr_pkg::value_t base_value;
  ctr_pkg::value_t decr_ext;
  ctr_pkg::value_t value_temp;
  ctr_pkg::value_t value_wrapped;

  // --------------------------------------------------------------------------
  // Next value
  // --------------------------------------------------------------------------

  // With reinit the decrement applies to the initial value
  assign base_value = ctr.reinit ? ctr.initial_value : ctr.value;
  assign decr_ext   = ctr.decr_valid ? ctr_pkg::value_t'(ctr.decr) : '0;

  // Going below zero wraps at the vector width first
  assign value_temp = base_value - decr_ext;

  // Pulling the wrapped code down by the margin lands it back in range
  assign value_wrapped = value_temp - ctr_pkg::value_t'(MARGIN);

  // Anything above the range can only come from an underflow
  assign ctr.value_next = (value_temp > `CTR_MAX_VALUE) ? value_wrapped : value_temp;

  // --------------------------------------------------------------------------
  // State
  // --------------------------------------------------------------------------

  // Value follows value_next only on a command
  always_ff @(posedge clk) begin
    if (reset) begin
      ctr.value <= ctr.initial_value;
    end else if (ctr.decr_valid || ctr.reinit) begin
      ctr.value <= ctr.value_next;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Counter stays inside its range
  value_in_range_a : assert property (@(posedge clk) disable iff (reset)
    ctr.value <= `CTR_MAX_VALUE);

  // value_next is always what value becomes one cycle later
  value_next_propagates_a : assert property (@(posedge clk) disable iff (reset)
    1'b1 |=> ctr.value == $past(ctr.value_next));

endmodule

// ==== source/ctr_axil_top.sv ====
// --------------------------------------------------------------------------
// Counter block top level
// Wrapping down-counter behind an AXI4-Lite slave. The write side decodes
// commands, the counter processes them and the read side reports state
// --------------------------------------------------------------------------

module ctr_axil_top (
  input  logic           clk,
  input  logic           reset,
  // Write address channel
  input  ctr_pkg::addr_t awaddr,
  input  logic           awvalid,
  output logic           awready,
  // Write data channel
  input  ctr_pkg::data_t wdata,
  input  logic [3:0]     wstrb,
  input  logic           wvalid,
  output logic           wready,
  // Write response channel
  output ctr_pkg::resp_t bresp,
  output logic           bvalid,
  input  logic           bready,
  // Read address channel
  input  ctr_pkg::addr_t araddr,
  input  logic           arvalid,
  output logic           arready,
  // Read data channel
  output ctr_pkg::data_t rdata,
  output ctr_pkg::resp_t rresp,
  output logic           rvalid,
  input  logic           rready
);

  // Commands and counter state shared by the three blocks
  ctr_cmd_if u_cmd_if ();

  // Write path and command decoder
  axil_cmd_slave u_cmd_slave (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .cmd     (u_cmd_if.cmd)
  );

  // The counter itself
  counter_decr u_counter (
    .clk   (clk),
    .reset (reset),
    .ctr   (u_cmd_if.ctr)
  );

  // Wrap counting and read path
  axil_status_reader u_status_reader (
    .clk     (clk),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .mon     (u_cmd_if.mon)
  );

endmodule

// ==== source/ctr_cmd_if.sv ====
// --------------------------------------------------------------------------
// Counter command interface
// Carries the decoded commands from the write side into the counter and
// the counter state out to the read side
// --------------------------------------------------------------------------

interface ctr_cmd_if;

  // Command side, driven by the write channel decoder
  ctr_pkg::value_t initial_value;
  logic            decr_valid;
  ctr_pkg::decr_t  decr;
  logic            reinit;

  // Counter state, driven by the counter
  ctr_pkg::value_t value;
  ctr_pkg::value_t value_next;

  // Write channel decoder
  modport cmd (
    output initial_value, decr_valid, decr, reinit
  );

  // Counter
  modport ctr (
    input  initial_value, decr_valid, decr, reinit,
    output value, value_next
  );

  // Status reader watches everything
  modport mon (
    input initial_value, decr_valid, decr, reinit, value, value_next
  );

endinterface

// ==== source/ctr_defs.svh ====
// --------------------------------------------------------------------------
// Counter block definitions
// Range and decrement limits of the wrapping down-counter, the widths that
// follow from them and the AXI4-Lite register map
// --------------------------------------------------------------------------

`ifndef CTR_DEFS_SVH
`define CTR_DEFS_SVH

// Counter range runs from 0 up to this value inclusive
`define CTR_MAX_VALUE 99
// Largest decrement a single command may carry
`define CTR_MAX_DECR 7

// Widths that follow from the limits above
`define CTR_VALUE_W 7
`define CTR_DECR_W 3
`define CTR_WRAP_W 16

// Bus widths
`define CTR_ADDR_W 4
`define CTR_DATA_W 32

// Register offsets
`define CTR_REG_INIT 4'h0
`define CTR_REG_CMD 4'h4
`define CTR_REG_VALUE 4'h8
`define CTR_REG_WRAPS 4'hC

// Bit of a CMD write that requests a reinit
`define CTR_CMD_REINIT_BIT 8

`endif

// ==== source/ctr_pkg.sv ====
// --------------------------------------------------------------------------
// Counter block types
// Vector types for counter values, decrements, wrap counts and bus fields,
// the AXI response codes and the state encodings of both bus channels
// --------------------------------------------------------------------------

`include "ctr_defs.svh"

package ctr_pkg;

  // Counter value in the range 0 to the maximum value
  typedef logic [`CTR_VALUE_W-1:0] value_t;

  // Decrement amount carried by one command
  typedef logic [`CTR_DECR_W-1:0] decr_t;

  // Wrap event count, rolls over at its own width
  typedef logic [`CTR_WRAP_W-1:0] wrap_t;

  // Bus address and data word
  typedef logic [`CTR_ADDR_W-1:0] addr_t;
  typedef logic [`CTR_DATA_W-1:0] data_t;

  // AXI response field
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Write channel states
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_e;

  // Read channel states
  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

endpackage

// ==== tests/ctr_axil_tb.sv ====
// --------------------------------------------------------------------------
// Counter block testbench
// Plays a table of AXI4-Lite register accesses into the counter block and
// compares each response and read word with the value in the table
// --------------------------------------------------------------------------

module ctr_axil_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // Longest wait for any handshake, in clock cycles
  localparam int WAIT_LIMIT = 50;

  logic           clk;
  logic           reset;
  ctr_pkg::addr_t awaddr;
  logic           awvalid;
  logic           awready;
  ctr_pkg::data_t wdata;
  logic [3:0]     wstrb;
  logic           wvalid;
  logic           wready;
  ctr_pkg::resp_t bresp;
  logic           bvalid;
  logic           bready;
  ctr_pkg::addr_t araddr;
  logic           arvalid;
  logic           arready;
  ctr_pkg::data_t rdata;
  ctr_pkg::resp_t rresp;
  logic           rvalid;
  logic           rready;

  int     errors;
  int     timeouts;
  integer seed;

  ctr_axil_top DUT (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  // 20 ns clock period
  always #10 clk = ~clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Inputs always change a little after the rising edge
  task automatic step_cycle;
    @(posedge clk);
    #2;
  endtask

  task automatic check_resp(input ctr_pkg::resp_t got, input ctr_pkg::resp_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s gave response %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input ctr_pkg::data_t got, input ctr_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s gave data 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  // Address and data go out together, then bready follows a random delay
  task automatic write_register(input ctr_pkg::addr_t addr, input ctr_pkg::data_t data,
                                output ctr_pkg::resp_t resp, output bit ok);
    int cycles;
    int hold;
    bit done;
    ok      = 1'b0;
    resp    = '0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    done    = 1'b0;
    cycles  = 0;
    // Ready is sampled mid-cycle, the transfer happens at the next edge
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      done = awready && wready;
      step_cycle();
      cycles++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!done) begin
      timeouts++;
      $display("Timeout at %0t ns: write to offset 0x%h was never accepted", $time, addr);
      return;
    end
    hold = $unsigned($random(seed)) % 4;
    repeat (hold) step_cycle();
    bready = 1'b1;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if (bvalid) begin
        done = 1'b1;
        resp = bresp;
      end
      step_cycle();
      cycles++;
    end
    bready = 1'b0;
    if (!done) begin
      timeouts++;
      $display("Timeout at %0t ns: no write response for offset 0x%h", $time, addr);
      return;
    end
    ok = 1'b1;
  endtask

  // Same pattern on the read channel, rready held back at random
  task automatic read_register(input ctr_pkg::addr_t addr, output ctr_pkg::data_t data,
                               output ctr_pkg::resp_t resp, output bit ok);
    int cycles;
    int hold;
    bit done;
    ok      = 1'b0;
    data    = '0;
    resp    = '0;
    araddr  = addr;
    arvalid = 1'b1;
    done    = 1'b0;
    cycles  = 0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      done = arready;
      step_cycle();
      cycles++;
    end
    arvalid = 1'b0;
    if (!done) begin
      timeouts++;
      $display("Timeout at %0t ns: read of offset 0x%h was never accepted", $time, addr);
      return;
    end
    hold = $unsigned($random(seed)) % 4;
    repeat (hold) step_cycle();
    rready = 1'b1;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if (rvalid) begin
        done = 1'b1;
        data = rdata;
        resp = rresp;
      end
      step_cycle();
      cycles++;
    end
    rready = 1'b0;
    if (!done) begin
      timeouts++;
      $display("Timeout at %0t ns: no read data for offset 0x%h", $time, addr);
      return;
    end
    ok = 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial begin
    int             fd;
    int             got;
    int             line_no;
    string          line;
    logic [7:0]     op;
    ctr_pkg::addr_t addr;
    ctr_pkg::data_t wr_word;
    ctr_pkg::resp_t exp_resp;
    ctr_pkg::data_t exp_data;
    ctr_pkg::resp_t resp;
    ctr_pkg::data_t data;
    bit             ok;
    bit             stop;
    clk      = 1'b0;
    reset    = 1'b1;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = 4'h0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    errors   = 0;
    timeouts = 0;
    seed     = 32'h7513_c558;
    stop     = 1'b0;
    line_no  = 0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    step_cycle();
    fd = $fopen("tests/ctr_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file tests/ctr_tests.txt");
    end else begin
      while (!stop && !$feof(fd)) begin
        line = "";
        got  = $fgets(line, fd);
        line_no++;
        // Blank lines and comment lines carry no access
        if (got == 0 || line.len() == 0 || line[0] == "#") continue;
        got = $sscanf(line, "%c %h %h %h %h", op, addr, wr_word, exp_resp, exp_data);
        if (got != 5) continue;
        if (op == "W") begin
          write_register(addr, wr_word, resp, ok);
          if (!ok) stop = 1'b1;
          else check_resp(resp, exp_resp, $sformatf("line %0d write 0x%h", line_no, addr));
        end else if (op == "R") begin
          read_register(addr, data, resp, ok);
          if (!ok) begin
            stop = 1'b1;
          end else begin
            check_resp(resp, exp_resp, $sformatf("line %0d read 0x%h", line_no, addr));
            check_data(data, exp_data, $sformatf("line %0d read 0x%h", line_no, addr));
          end
        end else begin
          errors++;
          $display("Unknown operation on line %0d of the stimulus file", line_no);
        end
      end
      $fclose(fd);
    end
    $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/ctr_tests.txt ====
# Columns: op (W write, R read), offset, write data, expected resp, expected read data
# All fields hex; resp 0 is OKAY and 2 is SLVERR; read data is ignored on writes
R 8 00000000 0 00000063
R 0 00000000 0 00000063
R C 00000000 0 00000000
W 4 00000003 0 00000000
R 8 00000000 0 00000060
W 4 00000007 0 00000000
R 8 00000000 0 00000059
W 4 00000000 0 00000000
R 8 00000000 0 00000059
R C 00000000 0 00000000
W 0 00000005 0 00000000
R 0 00000000 0 00000005
W 4 00000107 0 00000000
R 8 00000000 0 00000062
R C 00000000 0 00000001
W 4 00000100 0 00000000
R 8 00000000 0 00000005
W 4 00000003 0 00000000
R 8 00000000 0 00000002
W 4 00000003 0 00000000
R 8 00000000 0 00000063
R C 00000000 0 00000002
W 0 00000078 0 00000000
R 0 00000000 0 00000063
W C 00000011 2 00000000
R 4 00000000 2 00000000
R 8 00000000 0 00000063
